//--- logic/engine_macros.svh
`ifndef ENGINE_MACROS_SVH
`define ENGINE_MACROS_SVH

// Output channels computed per convolution
`define ENGINE_CONV_CHANNELS 4

// Word address width on all ports
`define ENGINE_ADDR_W 30

// Accumulator width for up to 255 full-scale products
`define ENGINE_ACC_W 40

// op_num and element counter width
`define ENGINE_CNT_W 8

`endif

//--- logic/engine_op_pkg.sv
package engine_op_pkg;

	// Host operation codes
	typedef enum logic [2:0] {
		OP_CONV    = 3'd1,
		OP_MAXPOOL = 3'd4,
		OP_AVEPOOL = 3'd5
	} op_code_e;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DRAIN,
		WRITE,
		FINISH
	} ctrl_state_e;

endpackage

//--- logic/engine_data_pkg.sv
`include "engine_macros.svh"

package engine_data_pkg;

	// Signed Q8.8 sample
	typedef logic signed [15:0] sample_t;

	// Word address
	typedef logic [`ENGINE_ADDR_W-1:0] addr_t;

	// Full Q16.16 product of two samples
	typedef logic signed [31:0] prod_t;

	// Accumulator for products and pool sums
	typedef logic signed [`ENGINE_ACC_W-1:0] acc_t;

endpackage

//--- logic/mac_unit.sv
`timescale 1ns/1ps

module mac_unit
	import engine_data_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    acc_clear,
	input  logic    mac_en,
	input  logic    pair_valid,
	input  logic    pair_last,
	input  sample_t pair_data,
	input  sample_t pair_weight,
	output logic    mac_valid,
	output sample_t mac_result
);

	localparam sample_t SAMPLE_MAX = 16'sh7fff;
	localparam sample_t SAMPLE_MIN = 16'sh8000;

	prod_t   prod;
	acc_t    acc;
	acc_t    acc_next;
	acc_t    acc_shift;
	sample_t sat_value;
	logic    take;

	assign take      = mac_en & pair_valid;
	assign prod      = pair_data * pair_weight;
	assign acc_next  = acc + acc_t'(prod);

	// Q16.16 sum back to Q8.8
	assign acc_shift = acc_next >>> 8;

	always_comb begin
		if (acc_shift > acc_t'(SAMPLE_MAX)) begin
			sat_value = SAMPLE_MAX;
		end else if (acc_shift < acc_t'(SAMPLE_MIN)) begin
			sat_value = SAMPLE_MIN;
		end else begin
			sat_value = sample_t'(acc_shift);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mac_valid <= 1'b0;
		end else begin
			mac_valid <= take & pair_last;
		end
	end

	always_ff @(posedge clk) begin
		if (acc_clear) begin
			acc <= '0;
		end else if (take) begin
			acc <= acc_next;
		end
		if (take && pair_last) begin
			mac_result <= sat_value;
		end
	end

endmodule

//--- logic/pool_unit.sv
`timescale 1ns/1ps
`include "engine_macros.svh"

module pool_unit
	import engine_data_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     acc_clear,
	input  logic                     pool_en,
	input  logic                     pool_avg,
	input  logic                     pair_valid,
	input  logic                     pair_last,
	input  sample_t                  pair_data,
	input  logic [`ENGINE_CNT_W-1:0] op_num,
	output logic                     pool_valid,
	output sample_t                  pool_result
);

	localparam int W         = `ENGINE_ACC_W;
	localparam int DIV_CNT_W = $clog2(W);

	sample_t              max_r;
	sample_t              max_next;
	acc_t                 sum_r;
	acc_t                 sum_next;
	logic                 take_last;
	logic                 div_busy;
	logic                 div_neg;
	logic                 div_done;
	logic [DIV_CNT_W-1:0] div_cnt;
	logic [W-1:0]         divisor;
	logic [W-1:0]         div_quo;
	logic [W-1:0]         div_rem;
	logic [W-1:0]         rem_sh;
	logic [W-1:0]         rem_next;
	logic [W-1:0]         quo_next;
	logic [W-1:0]         quo_signed;
	logic                 fits;

	assign take_last = pool_en & pair_valid & pair_last;
	assign max_next  = (pair_data > max_r) ? pair_data : max_r;
	assign sum_next  = sum_r + acc_t'(pair_data);

	// Restoring division of |sum| by op_num with one quotient bit per cycle
	assign divisor    = {{(W - `ENGINE_CNT_W){1'b0}}, op_num};
	assign rem_sh     = {div_rem[W-2:0], div_quo[W-1]};
	assign fits       = (rem_sh >= divisor);
	assign rem_next   = fits ? rem_sh - divisor : rem_sh;
	assign quo_next   = {div_quo[W-2:0], fits};
	assign quo_signed = div_neg ? -quo_next : quo_next;
	assign div_done   = div_busy && (div_cnt == DIV_CNT_W'(W - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pool_valid <= 1'b0;
			div_busy   <= 1'b0;
			div_cnt    <= '0;
		end else begin
			pool_valid <= (take_last & ~pool_avg) | div_done;
			if (take_last && pool_avg) begin
				div_busy <= 1'b1;
				div_cnt  <= '0;
			end else if (div_done) begin
				div_busy <= 1'b0;
			end else if (div_busy) begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (acc_clear) begin
			max_r <= 16'sh8000;
			sum_r <= '0;
		end else if (pool_en && pair_valid) begin
			max_r <= max_next;
			sum_r <= sum_next;
		end
		if (take_last && pool_avg) begin
			div_neg <= sum_next[W-1];
			div_quo <= sum_next[W-1] ? -sum_next : sum_next;
			div_rem <= '0;
		end else if (div_busy) begin
			div_quo <= quo_next;
			div_rem <= rem_next;
		end
		if (take_last && !pool_avg) begin
			pool_result <= max_next;
		end else if (div_done) begin
			pool_result <= sample_t'(quo_signed);
		end
	end

endmodule

//--- logic/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch
	import engine_data_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    fetch_req,
	input  addr_t   fetch_data_addr,
	input  addr_t   fetch_weight_addr,
	input  logic    need_weight,
	input  logic    data_we,
	input  sample_t data_rdata,
	input  logic    weight_we,
	input  sample_t weight_rdata,
	output logic    data_rd_en,
	output addr_t   data_addr,
	output logic    weight_rd_en,
	output addr_t   weight_addr,
	output logic    pair_valid,
	output sample_t pair_data,
	output sample_t pair_weight
);

	logic busy;
	logic data_pend;
	logic weight_pend;
	logic data_left;
	logic weight_left;

	// Strobes still missing after this cycle
	assign data_left   = data_pend & ~data_we;
	assign weight_left = weight_pend & ~weight_we;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy         <= 1'b0;
			data_pend    <= 1'b0;
			weight_pend  <= 1'b0;
			data_rd_en   <= 1'b0;
			weight_rd_en <= 1'b0;
			pair_valid   <= 1'b0;
		end else begin
			data_rd_en   <= 1'b0;
			weight_rd_en <= 1'b0;
			pair_valid   <= 1'b0;
			if (fetch_req) begin
				busy         <= 1'b1;
				data_pend    <= 1'b1;
				data_rd_en   <= 1'b1;
				weight_pend  <= need_weight;
				weight_rd_en <= need_weight;
			end else if (busy) begin
				data_pend   <= data_left;
				weight_pend <= weight_left;
				if (!data_left && !weight_left) begin
					busy       <= 1'b0;
					pair_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_req) begin
			data_addr   <= fetch_data_addr;
			weight_addr <= fetch_weight_addr;
		end
		if (data_we) begin
			pair_data <= data_rdata;
		end
		if (weight_we) begin
			pair_weight <= weight_rdata;
		end
	end

endmodule

//--- logic/engine_ctrl.sv
`timescale 1ns/1ps
`include "engine_macros.svh"

module engine_ctrl
	import engine_op_pkg::*;
	import engine_data_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  op_code_e                 op_type,
	input  logic [`ENGINE_CNT_W-1:0] op_num,
	input  addr_t                    data_start_addr,
	input  addr_t                    weight_start_addr,
	input  addr_t                    result_start_addr,
	input  logic                     pair_valid,
	input  logic                     mac_valid,
	input  sample_t                  mac_result,
	input  logic                     pool_valid,
	input  sample_t                  pool_result,
	output logic                     fetch_req,
	output addr_t                    fetch_data_addr,
	output addr_t                    fetch_weight_addr,
	output logic                     need_weight,
	output logic                     acc_clear,
	output logic                     mac_en,
	output logic                     pool_en,
	output logic                     pair_last,
	output logic                     result_we,
	output addr_t                    result_addr,
	output sample_t                  result_data,
	output logic                     done
);

	localparam int CHAN_W = $clog2(`ENGINE_CONV_CHANNELS) + 1;

	ctrl_state_e              state;
	logic [`ENGINE_CNT_W-1:0] elem_cnt;
	logic [CHAN_W-1:0]        chan_cnt;
	logic [CHAN_W-1:0]        chan_total;
	logic                     chan_last;
	logic                     last_wr;
	logic                     unit_valid;
	addr_t                    w_ptr;

	assign chan_total = mac_en ? CHAN_W'(`ENGINE_CONV_CHANNELS) : CHAN_W'(1);
	assign chan_last  = (chan_cnt == chan_total - 1'b1);
	assign pair_last  = (elem_cnt == op_num - 1'b1);
	assign unit_valid = mac_valid | pool_valid;

	// Weights of channel c follow channel c-1 directly, so one running pointer is enough
	assign need_weight       = mac_en;
	assign fetch_data_addr   = data_start_addr + addr_t'(elem_cnt);
	assign fetch_weight_addr = w_ptr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			elem_cnt  <= '0;
			chan_cnt  <= '0;
			last_wr   <= 1'b0;
			fetch_req <= 1'b0;
			acc_clear <= 1'b0;
			mac_en    <= 1'b0;
			pool_en   <= 1'b0;
			result_we <= 1'b0;
			done      <= 1'b0;
		end else begin
			fetch_req <= 1'b0;
			acc_clear <= 1'b0;
			result_we <= 1'b0;
			done      <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						elem_cnt <= '0;
						chan_cnt <= '0;
						case (op_type)
							OP_CONV: begin
								mac_en    <= 1'b1;
								acc_clear <= 1'b1;
								fetch_req <= 1'b1;
								state     <= FETCH;
							end
							OP_MAXPOOL, OP_AVEPOOL: begin
								pool_en   <= 1'b1;
								acc_clear <= 1'b1;
								fetch_req <= 1'b1;
								state     <= FETCH;
							end
							default: state <= FINISH;
						endcase
					end
				end
				FETCH: begin
					if (pair_valid) begin
						if (pair_last) begin
							state <= DRAIN;
						end else begin
							elem_cnt  <= elem_cnt + 1'b1;
							fetch_req <= 1'b1;
						end
					end
				end
				DRAIN: begin
					if (unit_valid) begin
						result_we <= 1'b1;
						last_wr   <= chan_last;
						state     <= WRITE;
						// Next channel starts fetching during the write
						if (!chan_last) begin
							chan_cnt  <= chan_cnt + 1'b1;
							elem_cnt  <= '0;
							acc_clear <= 1'b1;
							fetch_req <= 1'b1;
						end
					end
				end
				WRITE: begin
					if (last_wr) begin
						done  <= 1'b1;
						state <= FINISH;
					end else begin
						state <= FETCH;
					end
				end
				FINISH: begin
					// Unsupported ops arrive here without done raised
					if (done) begin
						mac_en  <= 1'b0;
						pool_en <= 1'b0;
						state   <= IDLE;
					end else begin
						done <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			w_ptr <= weight_start_addr;
		end else if (state == FETCH && pair_valid) begin
			w_ptr <= w_ptr + 1'b1;
		end
		if (state == DRAIN && unit_valid) begin
			result_addr <= result_start_addr + addr_t'(chan_cnt);
			result_data <= mac_en ? mac_result : pool_result;
		end
	end

endmodule

//--- logic/engine_top.sv
`timescale 1ns/1ps
`include "engine_macros.svh"

module engine_top
	import engine_op_pkg::*;
	import engine_data_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  op_code_e                 op_type,
	input  logic [`ENGINE_CNT_W-1:0] op_num,
	input  addr_t                    data_start_addr,
	input  addr_t                    weight_start_addr,
	input  addr_t                    result_start_addr,
	output logic                     done,
	output logic                     data_rd_en,
	output addr_t                    data_addr,
	input  logic                     data_we,
	input  sample_t                  data_rdata,
	output logic                     weight_rd_en,
	output addr_t                    weight_addr,
	input  logic                     weight_we,
	input  sample_t                  weight_rdata,
	output logic                     result_we,
	output addr_t                    result_addr,
	output sample_t                  result_data
);

	logic    fetch_req;
	addr_t   fetch_data_addr;
	addr_t   fetch_weight_addr;
	logic    need_weight;
	logic    acc_clear;
	logic    mac_en;
	logic    pool_en;
	logic    pool_avg;
	logic    pair_valid;
	logic    pair_last;
	sample_t pair_data;
	sample_t pair_weight;
	logic    mac_valid;
	sample_t mac_result;
	logic    pool_valid;
	sample_t pool_result;

	// op_type is held by the host for the whole operation
	assign pool_avg = (op_type == OP_AVEPOOL);

	engine_ctrl i_engine_ctrl (
		.clk               (clk),
		.rst_n             (rst_n),
		.start             (start),
		.op_type           (op_type),
		.op_num            (op_num),
		.data_start_addr   (data_start_addr),
		.weight_start_addr (weight_start_addr),
		.result_start_addr (result_start_addr),
		.pair_valid        (pair_valid),
		.mac_valid         (mac_valid),
		.mac_result        (mac_result),
		.pool_valid        (pool_valid),
		.pool_result       (pool_result),
		.fetch_req         (fetch_req),
		.fetch_data_addr   (fetch_data_addr),
		.fetch_weight_addr (fetch_weight_addr),
		.need_weight       (need_weight),
		.acc_clear         (acc_clear),
		.mac_en            (mac_en),
		.pool_en           (pool_en),
		.pair_last         (pair_last),
		.result_we         (result_we),
		.result_addr       (result_addr),
		.result_data       (result_data),
		.done              (done)
	);

	operand_fetch i_operand_fetch (
		.clk               (clk),
		.rst_n             (rst_n),
		.fetch_req         (fetch_req),
		.fetch_data_addr   (fetch_data_addr),
		.fetch_weight_addr (fetch_weight_addr),
		.need_weight       (need_weight),
		.data_we           (data_we),
		.data_rdata        (data_rdata),
		.weight_we         (weight_we),
		.weight_rdata      (weight_rdata),
		.data_rd_en        (data_rd_en),
		.data_addr         (data_addr),
		.weight_rd_en      (weight_rd_en),
		.weight_addr       (weight_addr),
		.pair_valid        (pair_valid),
		.pair_data         (pair_data),
		.pair_weight       (pair_weight)
	);

	mac_unit i_mac_unit (
		.clk         (clk),
		.rst_n       (rst_n),
		.acc_clear   (acc_clear),
		.mac_en      (mac_en),
		.pair_valid  (pair_valid),
		.pair_last   (pair_last),
		.pair_data   (pair_data),
		.pair_weight (pair_weight),
		.mac_valid   (mac_valid),
		.mac_result  (mac_result)
	);

	pool_unit i_pool_unit (
		.clk         (clk),
		.rst_n       (rst_n),
		.acc_clear   (acc_clear),
		.pool_en     (pool_en),
		.pool_avg    (pool_avg),
		.pair_valid  (pair_valid),
		.pair_last   (pair_last),
		.pair_data   (pair_data),
		.op_num      (op_num),
		.pool_valid  (pool_valid),
		.pool_result (pool_result)
	);

endmodule

//--- verification/engine_assertions.sv
`timescale 1ns/1ps

module engine_assertions
	import engine_op_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input logic        start,
	input ctrl_state_e state,
	input logic        fetch_req,
	input logic        pair_valid,
	input logic        result_we,
	input logic        done
);

	logic started;
	logic fetch_open;

	// data_rd_en follows fetch_req by one cycle, so an open fetch means a data read in flight
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			started    <= 1'b0;
			fetch_open <= 1'b0;
		end else begin
			if (start) begin
				started <= 1'b1;
			end
			if (fetch_req) begin
				fetch_open <= 1'b1;
			end else if (pair_valid) begin
				fetch_open <= 1'b0;
			end
		end
	end

	done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("done stayed high for more than one cycle");

	write_in_write_state: assert property (@(posedge clk) disable iff (!rst_n)
		result_we |-> (state == WRITE))
		else $error("result_we outside the WRITE state");

	one_read_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req |-> !fetch_open)
		else $error("new data read while the previous one is outstanding");

	no_read_before_start: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req |-> started)
		else $error("read request issued before any start");

endmodule

//--- verification/engine_tb.sv
`timescale 1ns/1ps
`include "engine_macros.svh"

module engine_tb
	import engine_op_pkg::*;
	import engine_data_pkg::*;
();

	localparam int MEM_AW = 11;
	localparam int SEED   = 32'h6604_7a87;

	logic                     clk;
	logic                     rst_n;
	logic                     start;
	op_code_e                 op_type;
	logic [`ENGINE_CNT_W-1:0] op_num;
	addr_t                    data_start_addr;
	addr_t                    weight_start_addr;
	addr_t                    result_start_addr;
	logic                     done;
	logic                     data_rd_en;
	addr_t                    data_addr;
	logic                     data_we = 1'b0;
	sample_t                  data_rdata = '0;
	logic                     weight_rd_en;
	addr_t                    weight_addr;
	logic                     weight_we = 1'b0;
	sample_t                  weight_rdata = '0;
	logic                     result_we;
	addr_t                    result_addr;
	sample_t                  result_data;

	sample_t data_mem   [0:(1 << MEM_AW) - 1];
	sample_t weight_mem [0:(1 << MEM_AW) - 1];

	// Operation in progress as seen by the compare process
	string    cur_test;
	op_code_e cur_op;
	int       cur_num;
	addr_t    cur_d;
	addr_t    cur_w;
	addr_t    cur_r;
	int       cur_exp_wr = 0;
	int       wr_count = 0;
	int       rd_count = 0;
	int       d_wait = 0;
	int       w_wait = 0;
	addr_t    d_req;
	addr_t    w_req;
	int       cycle_cnt = 0;
	int       cycle_budget = 50;

	engine_top i_engine_top (
		.clk               (clk),
		.rst_n             (rst_n),
		.start             (start),
		.op_type           (op_type),
		.op_num            (op_num),
		.data_start_addr   (data_start_addr),
		.weight_start_addr (weight_start_addr),
		.result_start_addr (result_start_addr),
		.done              (done),
		.data_rd_en        (data_rd_en),
		.data_addr         (data_addr),
		.data_we           (data_we),
		.data_rdata        (data_rdata),
		.weight_rd_en      (weight_rd_en),
		.weight_addr       (weight_addr),
		.weight_we         (weight_we),
		.weight_rdata      (weight_rdata),
		.result_we         (result_we),
		.result_addr       (result_addr),
		.result_data       (result_data)
	);

	bind engine_ctrl engine_assertions i_engine_assertions (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.state      (state),
		.fetch_req  (fetch_req),
		.pair_valid (pair_valid),
		.result_we  (result_we),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [MEM_AW-1:0] mem_idx(addr_t a);
		return a[MEM_AW-1:0];
	endfunction

	// Expected result for output idx of the current operation
	function automatic sample_t ref_result(op_code_e op, int idx);
		longint  sum;
		sample_t d;
		sample_t mx;
		sample_t res;
		sum = 0;
		mx  = 16'sh8000;
		for (int i = 0; i < cur_num; i++) begin
			d = data_mem[mem_idx(cur_d + addr_t'(i))];
			if (op == OP_CONV) begin
				sum += longint'(d) *
					longint'(weight_mem[mem_idx(cur_w + addr_t'(idx * cur_num + i))]);
			end else begin
				sum += longint'(d);
				if (d > mx) begin
					mx = d;
				end
			end
		end
		case (op)
			OP_CONV: begin
				// Q16.16 sum to Q8.8 clamped to the sample range
				sum = sum >>> 8;
				if (sum > 32767) begin
					res = 16'sh7fff;
				end else if (sum < -32768) begin
					res = 16'sh8000;
				end else begin
					res = sample_t'(sum);
				end
			end
			OP_MAXPOOL: res = mx;
			// Signed division already truncates toward zero
			OP_AVEPOOL: res = sample_t'(sum / longint'(cur_num));
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic stop_on_failure();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_sample(string name, sample_t expected, sample_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_addr(string name, addr_t expected, addr_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected address 'h%0h, actual 'h%0h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_count(string name, string what, int expected, int actual);
		if (actual != expected) begin
			$display("[ERROR] %s: %s expected %0d, actual %0d", name, what, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic load_data(addr_t base, int num, int lo, int hi);
		for (int i = 0; i < num; i++) begin
			data_mem[mem_idx(base + addr_t'(i))] =
				sample_t'(lo + int'($urandom_range(hi - lo, 0)));
		end
	endtask

	task automatic load_weights(addr_t base, int num, int lo, int hi);
		for (int i = 0; i < num; i++) begin
			weight_mem[mem_idx(base + addr_t'(i))] =
				sample_t'(lo + int'($urandom_range(hi - lo, 0)));
		end
	endtask

	task automatic run_op(string name, op_code_e op, logic [`ENGINE_CNT_W-1:0] num,
			addr_t d, addr_t w, addr_t r);
		int exp_rd;
		case (op)
			OP_CONV: begin
				cur_exp_wr = `ENGINE_CONV_CHANNELS;
				exp_rd     = int'(num) * 2 * `ENGINE_CONV_CHANNELS;
			end
			OP_MAXPOOL, OP_AVEPOOL: begin
				cur_exp_wr = 1;
				exp_rd     = int'(num);
			end
			default: begin
				cur_exp_wr = 0;
				exp_rd     = 0;
			end
		endcase
		cur_test = name;
		cur_op   = op;
		cur_num  = int'(num);
		cur_d    = d;
		cur_w    = w;
		cur_r    = r;
		wr_count = 0;
		rd_count = 0;
		cycle_budget += exp_rd * 6 + 300;
		start             <= 1'b1;
		op_type           <= op;
		op_num            <= num;
		data_start_addr   <= d;
		weight_start_addr <= w;
		result_start_addr <= r;
		do begin
			@(posedge clk);
		end while (done !== 1'b1);
		start <= 1'b0;
		check_count(name, "result writes", cur_exp_wr, wr_count);
		check_count(name, "read enables", exp_rd, rd_count);
		@(posedge clk);
	endtask

	// Memory model answering each read 1 to 4 cycles later
	always @(posedge clk) begin
		data_we   <= 1'b0;
		weight_we <= 1'b0;
		if (data_rd_en === 1'b1) begin
			d_req  = data_addr;
			d_wait = int'($urandom_range(4, 1));
		end
		if (weight_rd_en === 1'b1) begin
			w_req  = weight_addr;
			w_wait = int'($urandom_range(4, 1));
		end
		if (d_wait > 0) begin
			d_wait--;
			if (d_wait == 0) begin
				data_we    <= 1'b1;
				data_rdata <= data_mem[mem_idx(d_req)];
			end
		end
		if (w_wait > 0) begin
			w_wait--;
			if (w_wait == 0) begin
				weight_we    <= 1'b1;
				weight_rdata <= weight_mem[mem_idx(w_req)];
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n === 1'b1) begin
			rd_count += int'(data_rd_en) + int'(weight_rd_en);
		end
	end

	always @(posedge clk) begin
		if (rst_n === 1'b1 && result_we === 1'b1) begin
			if (wr_count >= cur_exp_wr) begin
				$display("Result write not expected during test %s", cur_test);
				stop_on_failure();
			end else begin
				check_addr(cur_test, cur_r + addr_t'(wr_count), result_addr);
				check_sample(cur_test, ref_result(cur_op, wr_count), result_data);
			end
			wr_count++;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_budget) begin
			$display("Timeout: no done within %0d cycles", cycle_budget);
			stop_on_failure();
		end
	end

	initial begin
		void'($urandom(SEED));
		rst_n             = 1'b0;
		start             = 1'b0;
		op_type           = OP_CONV;
		op_num            = '0;
		data_start_addr   = '0;
		weight_start_addr = '0;
		result_start_addr = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// Data 1..9 against channel c weights (c-1)*16*k
		for (int k = 1; k <= 9; k++) begin
			data_mem[mem_idx(addr_t'(k - 1))] = sample_t'(k * 256);
			for (int c = 0; c < `ENGINE_CONV_CHANNELS; c++) begin
				weight_mem[mem_idx(addr_t'(100 + c * 9 + k - 1))] = sample_t'((c - 1) * 16 * k);
			end
		end
		run_op("conv ramp", OP_CONV, 8'd9, 30'd0, 30'd100, 30'd0);
		repeat (3) @(posedge clk);

		// Even channels drive to +max, odd channels to -max
		load_data(30'd40, 8, 16'h4000, 16'h7fff);
		for (int c = 0; c < `ENGINE_CONV_CHANNELS; c++) begin
			if (c % 2 == 0) begin
				load_weights(addr_t'(200 + c * 8), 8, 16'h4000, 16'h7fff);
			end else begin
				load_weights(addr_t'(200 + c * 8), 8, -32767, -16384);
			end
		end
		run_op("conv saturate", OP_CONV, 8'd8, 30'd40, 30'd200, 30'd16);
		repeat (3) @(posedge clk);

		load_data(30'd300, 9, -32768, 32767);
		run_op("maxpool", OP_MAXPOOL, 8'd9, 30'd300, 30'd0, 30'd32);
		repeat (3) @(posedge clk);

		load_data(30'd400, 169, -32768, 32767);
		run_op("avepool random", OP_AVEPOOL, 8'd169, 30'd400, 30'd0, 30'd33);
		repeat (3) @(posedge clk);

		load_data(30'd600, 169, -20000, 5000);
		run_op("avepool negative", OP_AVEPOOL, 8'd169, 30'd600, 30'd0, 30'd34);
		repeat (3) @(posedge clk);

		run_op("unsupported op", op_code_e'(3'd2), 8'd9, 30'd0, 30'd0, 30'd40);
		repeat (3) @(posedge clk);

		// Back to back with one idle cycle between operations
		load_data(30'd800, 9, -32768, 32767);
		load_data(30'd820, 4, -4096, 4096);
		load_weights(30'd840, 16, -4096, 4096);
		load_data(30'd900, 169, -32768, 32767);
		run_op("b2b maxpool", OP_MAXPOOL, 8'd9, 30'd800, 30'd0, 30'd50);
		run_op("b2b conv", OP_CONV, 8'd4, 30'd820, 30'd840, 30'd51);
		run_op("b2b avepool", OP_AVEPOOL, 8'd169, 30'd900, 30'd0, 30'd60);
		run_op("b2b unsupported", op_code_e'(3'd7), 8'd3, 30'd0, 30'd0, 30'd61);
		run_op("b2b conv again", OP_CONV, 8'd9, 30'd0, 30'd100, 30'd70);

		repeat (5) @(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- engine_top.f
+incdir+logic
logic/engine_op_pkg.sv
logic/engine_data_pkg.sv
logic/mac_unit.sv
logic/pool_unit.sv
logic/operand_fetch.sv
logic/engine_ctrl.sv
logic/engine_top.sv
verification/engine_assertions.sv
verification/engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module engine_tb -f engine_top.f \
	--Mdir obj_dir -o engine_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/engine_sim > sim.log 2>&1

grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation did not complete, see sim.log"; exit 1; }
echo "Simulation passed"
